// File: include/eeprom_defs.svh
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// CLK cycles per quarter SCL period, one bit takes four quarters
`define EE_SCL_QUARTER 4

// control byte prefix of the 24C16 family
`define EE_DEVICE_CODE 4'b1010

// queue depths
`define EE_CMD_DEPTH 4
`define EE_RD_DEPTH 4

`endif

// File: logic/eeprom_pkg.sv
package eeprom_pkg;

    typedef enum logic {
        EE_WRITE = 1'b0,
        EE_READ  = 1'b1
    } ee_op_t;

    typedef logic [7:0] ee_byte_t;

    // one queued host request
    typedef struct packed {
        ee_op_t      op;
        logic [10:0] addr;
        ee_byte_t    data;   // ignored for reads
    } ee_cmd_t;

endpackage

// File: logic/queue_if.sv
`timescale 1ns/1ps

interface queue_if #(
    parameter type payload_t = logic [7:0]
) ();

    logic     push;
    payload_t push_data;
    logic     full;

    logic     pop;
    payload_t pop_data;    // head entry, valid while empty is low
    logic     empty;

    modport writer (
        output push,
        output push_data,
        input  full
    );

    modport store (
        input  push,
        input  push_data,
        output full,
        input  pop,
        output pop_data,
        output empty
    );

    modport reader (
        output pop,
        input  pop_data,
        input  empty
    );

endinterface

// File: logic/eeprom_cmd_intake.sv
`timescale 1ns/1ps

module eeprom_cmd_intake (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  logic [10:0]          addr,
    input  eeprom_pkg::ee_byte_t wr_data,
    queue_if.writer              cmd,
    output logic                 reject
);
    import eeprom_pkg::*;

    logic    strobe;
    logic    accept;
    ee_cmd_t next_cmd;

    assign strobe = wr | rd;
    // exactly one strobe and room in the queue
    assign accept = (wr ^ rd) & ~cmd.full;

    always_comb
    begin
        next_cmd.op   = rd ? EE_READ : EE_WRITE;
        next_cmd.addr = addr;
        next_cmd.data = wr_data;
    end

    assign cmd.push      = accept;
    assign cmd.push_data = next_cmd;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            reject <= 1'b0;
        else
            reject <= strobe & ~accept;   // pulse on the cycle after
    end

endmodule

// File: logic/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic   CLK,
    input  logic   RESET,
    queue_if.store q
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign do_push = q.push & ~q.full;
    assign do_pop  = q.pop & ~q.empty;

    assign q.full     = (count == (AW+1)'(DEPTH));
    assign q.empty    = (count == '0);
    assign q.pop_data = mem[rd_ptr];   // fall-through head

    always_ff @(posedge CLK)
    begin
        if (do_push)
            mem[wr_ptr] <= q.push_data;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

endmodule

// File: logic/i2c_eeprom_master.sv
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module i2c_eeprom_master (
    input  logic    CLK,
    input  logic    RESET,
    queue_if.reader cmd,
    queue_if.writer rdq,
    output logic    scl,
    output logic    sda_low,
    input  logic    sda_in,
    output logic    done,
    output logic    nack_err
);
    import eeprom_pkg::*;

    localparam int QUARTER = `EE_SCL_QUARTER;
    localparam int QW      = (QUARTER > 1) ? $clog2(QUARTER) : 1;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA,
        S_RSTART,
        S_CTRL_R,
        S_READ,
        S_STOP
    } state_t;

    state_t        state;
    ee_cmd_t       cur;         // command in flight
    logic [QW-1:0] qcnt;
    logic [1:0]    qtr;         // scl low in 0,1 and high in 2,3
    logic [3:0]    bitn;        // 8 is the acknowledge slot
    logic [7:0]    shreg;
    logic          nack;
    logic          tick;
    logic          slot_end;
    logic          sample;
    logic          byte_slot;
    logic          writing;
    logic          bit_low;
    logic          take;

    assign tick      = (qcnt == QW'(QUARTER - 1));
    assign slot_end  = tick && (qtr == 2'd3);
    assign sample    = tick && (qtr == 2'd2);   // middle of scl high
    assign byte_slot = state inside {S_CTRL_W, S_ADDR, S_DATA, S_CTRL_R, S_READ};
    assign writing   = byte_slot && (state != S_READ);
    assign bit_low   = writing && (bitn != 4'd8) && !shreg[7];

    // a read never starts without room for its result
    assign take    = (state == S_IDLE) && !cmd.empty && !rdq.full && !done;
    assign cmd.pop = take;

    assign rdq.push      = done && (cur.op == EE_READ) && !nack_err;
    assign rdq.push_data = shreg;

    // quarter timebase, parked while idle
    always_ff @(posedge CLK)
    begin
        if (RESET || state == S_IDLE)
        begin
            qcnt <= '0;
            qtr  <= 2'd0;
        end
        else if (tick)
        begin
            qcnt <= '0;
            qtr  <= qtr + 2'd1;
        end
        else
        begin
            qcnt <= qcnt + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl     <= 1'b1;
            sda_low <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    scl     <= 1'b1;
                    sda_low <= 1'b0;
                end
                S_START:
                begin
                    scl     <= 1'b1;
                    sda_low <= qtr[1];   // falls with scl high
                end
                S_RSTART:
                begin
                    scl     <= qtr[1];
                    sda_low <= (qtr == 2'd3);
                end
                S_STOP:
                begin
                    scl     <= qtr[1];
                    sda_low <= (qtr == 2'd1) || (qtr == 2'd2);   // rises in last quarter
                end
                default:
                begin
                    scl <= qtr[1];
                    if (qtr != 2'd0)   // hold through the scl fall
                        sda_low <= bit_low;
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= S_IDLE;
            bitn     <= 4'd0;
            nack     <= 1'b0;
            done     <= 1'b0;
            nack_err <= 1'b0;
        end
        else
        begin
            done     <= 1'b0;
            nack_err <= 1'b0;
            if (take)
            begin
                state <= S_START;
                bitn  <= 4'd0;
                nack  <= 1'b0;
            end
            else if (sample && writing && bitn == 4'd8 && sda_in)
                nack <= 1'b1;
            else if (slot_end)
            begin
                if (byte_slot && bitn != 4'd8)
                    bitn <= bitn + 4'd1;
                else
                begin
                    bitn <= 4'd0;
                    case (state)
                        S_START:  state <= S_CTRL_W;
                        S_CTRL_W: state <= nack ? S_STOP : S_ADDR;
                        S_ADDR:   state <= nack ? S_STOP :
                                           (cur.op == EE_READ) ? S_RSTART : S_DATA;
                        S_RSTART: state <= S_CTRL_R;
                        S_CTRL_R: state <= nack ? S_STOP : S_READ;
                        S_STOP:
                        begin
                            state    <= S_IDLE;
                            done     <= 1'b1;
                            nack_err <= nack;
                        end
                        default:  state <= S_STOP;   // data or read byte finished
                    endcase
                end
            end
        end
    end

    // shared shifter, out on writes and in on the read byte
    always_ff @(posedge CLK)
    begin
        if (take)
            cur <= cmd.pop_data;
        if (slot_end)
        begin
            if (writing && bitn != 4'd8)
                shreg <= {shreg[6:0], 1'b0};
            else if (state == S_START)
                shreg <= {`EE_DEVICE_CODE, cur.addr[10:8], 1'b0};
            else if (state == S_RSTART)
                shreg <= {`EE_DEVICE_CODE, cur.addr[10:8], 1'b1};
            else if (state == S_CTRL_W)
                shreg <= cur.addr[7:0];
            else if (state == S_ADDR)
                shreg <= cur.data;
        end
        else if (sample && state == S_READ && bitn != 4'd8)
            shreg <= {shreg[6:0], sda_in};
    end

endmodule

// File: logic/eeprom_access_top.sv
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module eeprom_access_top (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  logic [10:0]          addr,
    input  eeprom_pkg::ee_byte_t wr_data,
    input  logic                 rd_pop,
    output eeprom_pkg::ee_byte_t rd_data,
    output logic                 rd_valid,
    output logic                 busy,
    output logic                 reject,
    output logic                 done,
    output logic                 nack_err,
    output logic                 scl,
    inout  wire                  sda
);
    import eeprom_pkg::*;

    logic sda_low;

    queue_if #(.payload_t(ee_cmd_t))  cmd_q ();
    queue_if #(.payload_t(ee_byte_t)) rd_q ();

    eeprom_cmd_intake u_intake (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .cmd     (cmd_q),
        .reject  (reject)
    );

    sync_fifo #(.payload_t(ee_cmd_t), .DEPTH(`EE_CMD_DEPTH)) cmd_fifo (
        .CLK   (CLK),
        .RESET (RESET),
        .q     (cmd_q)
    );

    sync_fifo #(.payload_t(ee_byte_t), .DEPTH(`EE_RD_DEPTH)) rd_fifo (
        .CLK   (CLK),
        .RESET (RESET),
        .q     (rd_q)
    );

    i2c_eeprom_master u_master (
        .CLK      (CLK),
        .RESET    (RESET),
        .cmd      (cmd_q),
        .rdq      (rd_q),
        .scl      (scl),
        .sda_low  (sda_low),
        .sda_in   (sda),
        .done     (done),
        .nack_err (nack_err)
    );

    // host side of the read queue
    assign rd_q.pop = rd_pop;
    assign rd_data  = rd_q.pop_data;
    assign rd_valid = ~rd_q.empty;
    assign busy     = cmd_q.full;

    assign sda = sda_low ? 1'b0 : 1'bz;   // open drain

endmodule

// File: verif/eeprom_model.sv
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module eeprom_model (
    input logic scl,
    inout wire  sda
);
    logic [7:0]  mem [2048];
    logic [7:0]  sh;
    logic [7:0]  out;
    logic [10:0] ptr;
    logic [2:0]  hi;
    logic [1:0]  phase;     // control, address, data
    int          bitc;      // 9 marks the acknowledge slot
    logic        active;
    logic        reading;
    logic        send_next;
    logic        drop;
    logic        ack;
    logic        drive_low;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = i[7:0] ^ 8'h5a;
        active    = 1'b0;
        reading   = 1'b0;
        drive_low = 1'b0;
        ptr       = '0;
        bitc      = 0;
    end

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            active    = 1'b1;
            bitc      = 0;
            phase     = 2'd0;
            reading   = 1'b0;
            send_next = 1'b0;
            drop      = 1'b0;
            drive_low = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            active    = 1'b0;   // stop
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (active && bitc < 8)
        begin
            if (!reading)
                sh = {sh[6:0], sda};
            bitc = bitc + 1;
        end
    end

    always @(negedge scl)
    begin
        if (active)
        begin
            if (bitc == 8)
            begin
                bitc = 9;
                if (reading)
                    drive_low = 1'b0;   // master answers here
                else
                begin
                    ack = 1'b1;
                    case (phase)
                        2'd0:
                        begin
                            if (sh[7:4] != `EE_DEVICE_CODE)
                                ack = 1'b0;
                            else
                            begin
                                hi = sh[3:1];
                                if (sh[0])
                                    send_next = 1'b1;
                                else
                                    phase = 2'd1;
                            end
                        end
                        2'd1:
                        begin
                            ptr   = {hi, sh};
                            phase = 2'd2;
                        end
                        default:
                        begin
                            if (ptr >= 11'h700)
                                ack = 1'b0;   // protected block
                            else
                                mem[ptr] = sh;
                            ptr = ptr + 1'b1;
                        end
                    endcase
                    drive_low = ack;
                    drop      = ~ack;
                end
            end
            else if (bitc == 9)
            begin
                drive_low = 1'b0;
                bitc      = 0;
                if (drop || reading)
                    active = 1'b0;
                else if (send_next)
                begin
                    reading   = 1'b1;
                    out       = mem[ptr];
                    ptr       = ptr + 1'b1;
                    drive_low = ~out[7];
                end
            end
            else if (reading)
                drive_low = ~out[7 - bitc];
        end
    end

endmodule

// File: verif/eeprom_access_asserts.sv
`timescale 1ns/1ps

module eeprom_access_asserts (
    input logic CLK,
    input logic RESET,
    input logic scl,
    input wire  sda,
    input logic sda_low,
    input logic done,
    input logic reject,
    input logic nack_err,
    input logic cmd_push,
    input logic cmd_full,
    input logic cmd_pop,
    input logic cmd_empty
);

    // only the master's own start or stop moves sda with scl high
    sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && $changed(sda)) |-> $changed(sda_low))
        else $error("sda moved while scl was high");

    done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        done |=> !done)
        else $error("done held longer than one cycle");

    reject_pulse: assert property (@(posedge CLK) disable iff (RESET)
        reject |=> !reject)
        else $error("reject held longer than one cycle");

    push_room: assert property (@(posedge CLK) disable iff (RESET)
        cmd_push |-> !cmd_full)
        else $error("push into a full command queue");

    pop_data: assert property (@(posedge CLK) disable iff (RESET)
        cmd_pop |-> !cmd_empty)
        else $error("pop from an empty command queue");

    nack_with_done: assert property (@(posedge CLK) disable iff (RESET)
        nack_err |-> done)
        else $error("nack_err without done");

endmodule

bind eeprom_access_top eeprom_access_asserts u_asserts (
    .CLK       (CLK),
    .RESET     (RESET),
    .scl       (scl),
    .sda       (sda),
    .sda_low   (sda_low),
    .done      (done),
    .reject    (reject),
    .nack_err  (nack_err),
    .cmd_push  (cmd_q.push),
    .cmd_full  (cmd_q.full),
    .cmd_pop   (cmd_q.pop),
    .cmd_empty (cmd_q.empty)
);

// File: verif/tb_eeprom_access.sv
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module tb_eeprom_access;
    localparam int LIMIT = 40 * 4 * `EE_SCL_QUARTER;   // 40 scl periods

    logic        CLK = 1'b0;
    logic        RESET;
    logic        wr, rd, rd_pop;
    logic [10:0] addr;
    logic [7:0]  wr_data, rd_data;
    logic        rd_valid, busy, reject, done, nack_err, scl;
    wire         sda;
    logic [7:0]  ref_mem [2048];
    int          errors = 0;
    int          timeouts = 0;
    int          done_seen = 0;
    int          reject_seen = 0;
    int          accepted = 0;
    int          rejects_exp = 0;

    pullup (sda);

    eeprom_access_top uut (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wr_data(wr_data),
        .rd_pop(rd_pop), .rd_data(rd_data), .rd_valid(rd_valid), .busy(busy),
        .reject(reject), .done(done), .nack_err(nack_err), .scl(scl), .sda(sda)
    );

    eeprom_model u_slave (.scl(scl), .sda(sda));

    always #4 CLK = ~CLK;

    always @(negedge CLK)
    begin
        if (done)
            done_seen++;
        if (reject)
            reject_seen++;
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic strobe(input logic is_wr, input logic is_rd, input logic [10:0] a,
                          input logic [7:0] d);
        @(posedge CLK);
        #1;
        wr = is_wr;
        rd = is_rd;
        addr = a;
        wr_data = d;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_done(output logic nack);
        nack = 1'b0;
        for (int i = 0; i < LIMIT; i++)
        begin
            @(negedge CLK);
            if (done)
            begin
                nack = nack_err;
                return;
            end
        end
        $display("Timed out waiting for done.");
        timeouts++;
    endtask

    task automatic wait_valid();
        for (int i = 0; i < LIMIT; i++)
        begin
            @(negedge CLK);
            if (rd_valid)
                return;
        end
        $display("Timed out waiting for rd_valid.");
        timeouts++;
    endtask

    task automatic expect_no_done(input string why);
        for (int i = 0; i < LIMIT; i++)
        begin
            @(negedge CLK);
            if (done)
            begin
                $display("A transaction finished %s.", why);
                errors++;
                return;
            end
        end
    endtask

    task automatic pop_check(input logic [10:0] a);
        wait_valid();
        compare("rd_data", rd_data, ref_mem[a]);
        @(posedge CLK);
        #1 rd_pop = 1'b1;
        @(posedge CLK);
        #1 rd_pop = 1'b0;
    endtask

    task automatic burst(input logic [10:0] a, input int n, input int exp_acc);
        logic [10:0] q[$];
        logic        nack;
        logic        full_exp;
        for (int k = 0; k < n; k++)
        begin
            @(posedge CLK);
            #1;
            // first read goes straight to the idle master, the next ones fill the queue
            full_exp = (k > `EE_CMD_DEPTH);
            compare("busy", busy, full_exp);
            if (full_exp)
                rejects_exp++;
            else
                q.push_back(a + 11'(k));
            rd = 1'b1;
            addr = a + 11'(k);
        end
        @(posedge CLK);
        #1 rd = 1'b0;
        compare("accepted", q.size(), exp_acc);
        accepted += q.size();
        for (int k = 0; k < q.size() && k < `EE_RD_DEPTH; k++)
        begin
            wait_done(nack);
            compare("nack_err", nack, 1'b0);
        end
        if (q.size() > `EE_RD_DEPTH)
        begin
            expect_no_done("while the read queue was full");
            compare("rd_valid", rd_valid, 1'b1);
        end
        for (int k = 0; k < q.size(); k++)
        begin
            if (k == `EE_RD_DEPTH)
            begin
                wait_done(nack);
                compare("nack_err", nack, 1'b0);
            end
            pop_check(q[k]);
        end
    endtask

    initial
    begin
        int         fd;
        string      line;
        byte        op;
        logic [10:0] a;
        logic [7:0] d;
        int         e;
        logic       nack;

        RESET = 1'b1;
        wr = 1'b0;
        rd = 1'b0;
        rd_pop = 1'b0;
        addr = '0;
        wr_data = '0;
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = i[7:0] ^ 8'h5a;
        repeat (8) @(posedge CLK);
        #1 RESET = 1'b0;
        @(negedge CLK);
        compare("scl", scl, 1'b1);
        compare("sda", sda, 1'b1);
        compare("done", done, 1'b0);
        compare("nack_err", nack_err, 1'b0);
        compare("reject", reject, 1'b0);
        compare("rd_valid", rd_valid, 1'b0);

        fd = $fopen("verif/eeprom_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("The vector file could not be opened.");
            errors++;
        end
        else
        begin
            while ($fgets(line, fd))
            begin
                if (line.len() < 2 || line[0] == "#")
                    continue;
                void'($sscanf(line, "%c %h %h %h", op, a, d, e));
                case (op)
                    "W":
                    begin
                        strobe(1'b1, 1'b0, a, d);
                        accepted++;
                        compare("vector nack", e, a >= 11'h700);
                        if (a < 11'h700)
                            ref_mem[a] = d;
                        wait_done(nack);
                        compare("nack_err", nack, e);
                    end
                    "R":
                    begin
                        strobe(1'b0, 1'b1, a, 8'h00);
                        accepted++;
                        compare("vector data", e, ref_mem[a]);
                        wait_done(nack);
                        compare("nack_err", nack, 1'b0);
                        pop_check(a);
                    end
                    "D":
                    begin
                        strobe(1'b1, 1'b1, a, d);
                        rejects_exp++;
                        @(negedge CLK);
                        compare("reject", reject, e);
                        expect_no_done("after a double strobe");
                    end
                    "B":
                        burst(a, d, e);
                    default:
                    begin
                        $display("The vector file holds an unknown opcode.");
                        errors++;
                    end
                endcase
            end
            $fclose(fd);
        end

        repeat (4) @(negedge CLK);
        compare("done count", done_seen, accepted);
        compare("reject count", reject_seen, rejects_exp);
        $display("errors %0d timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: eeprom_access.f
+incdir+include
logic/eeprom_pkg.sv
logic/queue_if.sv
logic/eeprom_cmd_intake.sv
logic/sync_fifo.sv
logic/i2c_eeprom_master.sv
logic/eeprom_access_top.sv
verif/eeprom_model.sv
verif/eeprom_access_asserts.sv
verif/tb_eeprom_access.sv

// File: verif/eeprom_vectors.txt
# op addr data expect, all hex
# W expect=nack, R expect=read data, D expect=reject, B data=strobes expect=accepted
W 010 a5 0
R 010 00 a5
R 123 00 79
W 2ff 3c 0
R 2ff 00 3c
W 705 11 1
R 705 00 5f
W 7ff ee 1
R 7ff 00 a5
D 040 77 1
R 040 00 1a
W 6ff 81 0
R 6ff 00 81
B 300 06 05
R 011 00 4b
W 011 c3 0
R 011 00 c3
D 011 00 1
R 011 00 c3
